// File: include/ctrlParam_settings.svh
`ifndef CTRL_PARAM_SETTINGS_SVH
`define CTRL_PARAM_SETTINGS_SVH

// register bank shape
`define CP_LARGE_COUNT 2
`define CP_SMALL_COUNT 4
`define CP_LARGE_WIDTH 32
`define CP_HALF_WIDTH 16

// command word fields
`define CP_CODE_WIDTH 7

// first code of each register group, code 0 stays unused
`define CP_LARGE_CODE_BASE 1
`define CP_SMALL_CODE_BASE 5

// lead bytes of the responses
`define CP_RESP_ACK 8'h06
`define CP_RESP_NAK 8'h15
`define CP_RESP_ERR 8'h18
`define CP_RESP_READ 8'h52

`endif

// File: rtl/ctrlParamPkg.sv
`include "ctrlParam_settings.svh"

package ctrlParamPkg;

    // one host command, most significant byte arrives first
    typedef struct packed {
        logic isRead;
        logic [`CP_CODE_WIDTH-1:0] code;
        logic [`CP_LARGE_WIDTH-`CP_HALF_WIDTH-`CP_CODE_WIDTH-2:0] reserved;
        logic [`CP_HALF_WIDTH-1:0] data;
    } cmdWord_t;

    // register sets, index 0 in the low word
    typedef logic [`CP_LARGE_COUNT-1:0][`CP_LARGE_WIDTH-1:0] largeRegs_t;
    typedef logic [`CP_SMALL_COUNT-1:0][`CP_HALF_WIDTH-1:0] smallRegs_t;

    typedef enum logic [2:0] {
        respNone,
        respAck,
        respNak,
        respErr,
        respReadData
    } respKind_t;

    // outcome of one decoded command
    typedef struct packed {
        respKind_t kind;
        logic [`CP_HALF_WIDTH-1:0] readValue;
    } decodeResult_t;

endpackage

// File: rtl/cmdFrameAssembler.sv
`timescale 1ns/1ps

module cmdFrameAssembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wipe,
    input  logic [7:0]             byteIn,
    input  logic                   byteValid,
    output ctrlParamPkg::cmdWord_t cmdWord,
    output logic                   cmdValid
);

    // bytes taken so far in the current word
    logic [1:0] byteCount;
    // first three bytes, oldest in the top byte
    logic [23:0] gathered;

    // ------------------------------------------------------------------------
    // byte counter and word strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || wipe) begin
            byteCount <= 2'd0;
            cmdValid  <= 1'b0;
        end else begin
            cmdValid <= 1'b0;
            if (byteValid) begin
                // counter wraps back to zero after the fourth byte
                byteCount <= byteCount + 2'd1;
                if (byteCount == 2'd3) begin
                    cmdValid <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // shift register and finished word
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (byteValid) begin
            if (byteCount == 2'd3) begin
                cmdWord <= {gathered, byteIn};
            end else begin
                gathered <= {gathered[15:0], byteIn};
            end
        end
    end

endmodule

// File: rtl/ctrlParamDecoder.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module ctrlParamDecoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wipe,
    input  ctrlParamPkg::cmdWord_t      cmdWord,
    input  logic                        cmdValid,
    output ctrlParamPkg::largeRegs_t    shadowLarge,
    output ctrlParamPkg::smallRegs_t    shadowSmall,
    output logic [`CP_LARGE_COUNT-1:0]  largeUpdate,
    output logic [`CP_SMALL_COUNT-1:0]  smallUpdate,
    output logic                        allWritten,
    output ctrlParamPkg::decodeResult_t result,
    output logic                        resultValid
);

    import ctrlParamPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stEvaluate,
        stRespond
    } decState_t;

    decState_t state;
    cmdWord_t cmdReg;

    // halves seen since the last update pulse
    logic [`CP_LARGE_COUNT-1:0] pendingUpper;
    logic [`CP_LARGE_COUNT-1:0] pendingLower;
    // halves and small registers seen since rst or wipe
    logic [`CP_LARGE_COUNT-1:0] writtenUpper;
    logic [`CP_LARGE_COUNT-1:0] writtenLower;
    logic [`CP_SMALL_COUNT-1:0] writtenSmall;

    // decoded view of the held command
    logic [`CP_LARGE_COUNT-1:0] hitUpper;
    logic [`CP_LARGE_COUNT-1:0] hitLower;
    logic [`CP_SMALL_COUNT-1:0] hitSmall;
    logic codeValid;
    logic [`CP_HALF_WIDTH-1:0] readMux;

    logic [`CP_LARGE_COUNT-1:0] nextUpper;
    logic [`CP_LARGE_COUNT-1:0] nextLower;
    logic [`CP_LARGE_COUNT-1:0] pairDone;

    // ------------------------------------------------------------------------
    // code decode and read select
    // ------------------------------------------------------------------------
    always_comb begin
        hitUpper = '0;
        hitLower = '0;
        hitSmall = '0;
        readMux  = '0;
        // upper half on the odd code, lower half right after it
        for (int i = 0; i < `CP_LARGE_COUNT; i++) begin
            if (int'(cmdReg.code) == `CP_LARGE_CODE_BASE + 2 * i) begin
                hitUpper[i] = 1'b1;
                readMux     = shadowLarge[i][`CP_LARGE_WIDTH-1 -: `CP_HALF_WIDTH];
            end
            if (int'(cmdReg.code) == `CP_LARGE_CODE_BASE + 2 * i + 1) begin
                hitLower[i] = 1'b1;
                readMux     = shadowLarge[i][`CP_HALF_WIDTH-1:0];
            end
        end
        for (int j = 0; j < `CP_SMALL_COUNT; j++) begin
            if (int'(cmdReg.code) == `CP_SMALL_CODE_BASE + j) begin
                hitSmall[j] = 1'b1;
                readMux     = shadowSmall[j];
            end
        end
        codeValid = |{hitUpper, hitLower, hitSmall};
    end

    // a pair fires as soon as both halves are pending
    assign nextUpper = pendingUpper | hitUpper;
    assign nextLower = pendingLower | hitLower;
    assign pairDone  = nextUpper & nextLower;

    assign allWritten = &{writtenUpper, writtenLower, writtenSmall};

    // ------------------------------------------------------------------------
    // command FSM, idle -> evaluate -> respond
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || wipe) begin
            state            <= stIdle;
            shadowLarge      <= '0;
            shadowSmall      <= '0;
            pendingUpper     <= '0;
            pendingLower     <= '0;
            writtenUpper     <= '0;
            writtenLower     <= '0;
            writtenSmall     <= '0;
            largeUpdate      <= '0;
            smallUpdate      <= '0;
            result.kind      <= respNone;
            result.readValue <= '0;
            resultValid      <= 1'b0;
        end else begin
            largeUpdate <= '0;
            smallUpdate <= '0;
            resultValid <= 1'b0;
            case (state)
                stIdle: begin
                    if (cmdValid) begin
                        cmdReg <= cmdWord;
                        state  <= stEvaluate;
                    end
                end
                stEvaluate: begin
                    if (!cmdReg.isRead) begin
                        for (int i = 0; i < `CP_LARGE_COUNT; i++) begin
                            if (hitUpper[i]) begin
                                shadowLarge[i][`CP_LARGE_WIDTH-1 -: `CP_HALF_WIDTH] <=
                                    cmdReg.data;
                            end
                            if (hitLower[i]) begin
                                shadowLarge[i][`CP_HALF_WIDTH-1:0] <= cmdReg.data;
                            end
                        end
                        for (int j = 0; j < `CP_SMALL_COUNT; j++) begin
                            if (hitSmall[j]) begin
                                shadowSmall[j] <= cmdReg.data;
                            end
                        end
                        writtenUpper <= writtenUpper | hitUpper;
                        writtenLower <= writtenLower | hitLower;
                        writtenSmall <= writtenSmall | hitSmall;
                        // completed pairs leave the pending set
                        pendingUpper <= nextUpper & ~pairDone;
                        pendingLower <= nextLower & ~pairDone;
                        largeUpdate  <= pairDone;
                        smallUpdate  <= hitSmall;
                    end
                    state <= stRespond;
                end
                stRespond: begin
                    resultValid <= 1'b1;
                    if (cmdReg.isRead) begin
                        result.kind      <= codeValid ? respReadData : respErr;
                        result.readValue <= readMux;
                    end else begin
                        result.kind      <= codeValid ? respAck : respNak;
                        result.readValue <= '0;
                    end
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

// File: rtl/paramShadowLatch.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module paramShadowLatch (
    input  logic                       clk,
    input  logic                       rst,
    input  ctrlParamPkg::largeRegs_t   shadowLarge,
    input  ctrlParamPkg::smallRegs_t   shadowSmall,
    input  logic [`CP_LARGE_COUNT-1:0] largeUpdate,
    input  logic [`CP_SMALL_COUNT-1:0] smallUpdate,
    input  logic                       applyStrobe,
    output ctrlParamPkg::largeRegs_t   activeLarge,
    output ctrlParamPkg::smallRegs_t   activeSmall
);

    logic [`CP_LARGE_COUNT-1:0] pendingLarge;
    logic [`CP_SMALL_COUNT-1:0] pendingSmall;

    // an update pulse in the apply cycle counts as pending,
    // the shadow value already holds the new data then
    logic [`CP_LARGE_COUNT-1:0] dueLarge;
    logic [`CP_SMALL_COUNT-1:0] dueSmall;

    assign dueLarge = pendingLarge | largeUpdate;
    assign dueSmall = pendingSmall | smallUpdate;

    // ------------------------------------------------------------------------
    // pending tracking and copy to the active set
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pendingLarge <= '0;
            pendingSmall <= '0;
            activeLarge  <= '0;
            activeSmall  <= '0;
        end else if (applyStrobe) begin
            for (int i = 0; i < `CP_LARGE_COUNT; i++) begin
                if (dueLarge[i]) begin
                    activeLarge[i] <= shadowLarge[i];
                end
            end
            for (int j = 0; j < `CP_SMALL_COUNT; j++) begin
                if (dueSmall[j]) begin
                    activeSmall[j] <= shadowSmall[j];
                end
            end
            pendingLarge <= '0;
            pendingSmall <= '0;
        end else begin
            pendingLarge <= dueLarge;
            pendingSmall <= dueSmall;
        end
    end

endmodule

// File: rtl/responseEncoder.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module responseEncoder (
    input  logic                        clk,
    input  logic                        rst,
    input  ctrlParamPkg::decodeResult_t result,
    input  logic                        resultValid,
    output logic [7:0]                  respByte,
    output logic                        respValid
);

    import ctrlParamPkg::*;

    // data bytes still to send after the lead byte
    logic [1:0] bytesLeft;
    logic [`CP_HALF_WIDTH-1:0] dataHold;

    logic [7:0] leadByte;
    logic hasLead;

    // lead byte per result kind
    always_comb begin
        leadByte = 8'h00;
        hasLead  = 1'b1;
        case (result.kind)
            respAck:      leadByte = `CP_RESP_ACK;
            respNak:      leadByte = `CP_RESP_NAK;
            respErr:      leadByte = `CP_RESP_ERR;
            respReadData: leadByte = `CP_RESP_READ;
            default:      hasLead  = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // byte sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            bytesLeft <= 2'd0;
            respByte  <= 8'h00;
            respValid <= 1'b0;
        end else begin
            respValid <= 1'b0;
            if (resultValid && hasLead) begin
                respByte  <= leadByte;
                respValid <= 1'b1;
                bytesLeft <= (result.kind == respReadData) ? 2'd2 : 2'd0;
            end else if (bytesLeft != 2'd0) begin
                // high byte first, then low byte
                respByte  <= (bytesLeft == 2'd2) ? dataHold[15:8] : dataHold[7:0];
                respValid <= 1'b1;
                bytesLeft <= bytesLeft - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resultValid) begin
            dataHold <= result.readValue;
        end
    end

endmodule

// File: rtl/ctrlParamLink.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module ctrlParamLink (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 byteIn,
    input  logic                       byteValid,
    input  logic                       wipe,
    input  logic                       applyStrobe,
    output logic [7:0]                 respByte,
    output logic                       respValid,
    output ctrlParamPkg::largeRegs_t   activeLarge,
    output ctrlParamPkg::smallRegs_t   activeSmall,
    output logic [`CP_LARGE_COUNT-1:0] largeUpdate,
    output logic [`CP_SMALL_COUNT-1:0] smallUpdate,
    output logic                       allWritten
);

    import ctrlParamPkg::*;

    // ------------------------------------------------------------------------
    // stage links
    // ------------------------------------------------------------------------
    cmdWord_t cmdWord;
    logic cmdValid;
    largeRegs_t shadowLarge;
    smallRegs_t shadowSmall;
    decodeResult_t result;
    logic resultValid;

    // bytes to command words
    cmdFrameAssembler uAssembler (
        .clk       (clk),
        .rst       (rst),
        .wipe      (wipe),
        .byteIn    (byteIn),
        .byteValid (byteValid),
        .cmdWord   (cmdWord),
        .cmdValid  (cmdValid)
    );

    ctrlParamDecoder uDecoder (
        .clk         (clk),
        .rst         (rst),
        .wipe        (wipe),
        .cmdWord     (cmdWord),
        .cmdValid    (cmdValid),
        .shadowLarge (shadowLarge),
        .shadowSmall (shadowSmall),
        .largeUpdate (largeUpdate),
        .smallUpdate (smallUpdate),
        .allWritten  (allWritten),
        .result      (result),
        .resultValid (resultValid)
    );

    // active set only moves on the apply strobe
    paramShadowLatch uShadowLatch (
        .clk         (clk),
        .rst         (rst),
        .shadowLarge (shadowLarge),
        .shadowSmall (shadowSmall),
        .largeUpdate (largeUpdate),
        .smallUpdate (smallUpdate),
        .applyStrobe (applyStrobe),
        .activeLarge (activeLarge),
        .activeSmall (activeSmall)
    );

    responseEncoder uEncoder (
        .clk         (clk),
        .rst         (rst),
        .result      (result),
        .resultValid (resultValid),
        .respByte    (respByte),
        .respValid   (respValid)
    );

endmodule

// File: tb/ctrlParamChecker.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module ctrlParamChecker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 byteIn,
    input  logic                       byteValid,
    input  logic                       wipe,
    input  logic                       applyStrobe,
    input  logic [7:0]                 respByte,
    input  logic                       respValid,
    input  ctrlParamPkg::largeRegs_t   activeLarge,
    input  ctrlParamPkg::smallRegs_t   activeSmall,
    input  logic [`CP_LARGE_COUNT-1:0] largeUpdate,
    input  logic [`CP_SMALL_COUNT-1:0] smallUpdate,
    input  logic                       allWritten,
    input  int                         testId,
    input  logic                       checkPoint,
    input  logic                       testDone,
    input  logic                       finalize,
    output logic                       drained,
    output int                         errorTotal
);

    import ctrlParamPkg::*;

    localparam int PULSE_W = `CP_LARGE_COUNT + `CP_SMALL_COUNT;

    // ------------------------------------------------------------------------
    // model state
    // ------------------------------------------------------------------------
    logic [1:0] byteCount;
    logic [23:0] gathered;
    largeRegs_t shadowLarge;
    smallRegs_t shadowSmall;
    largeRegs_t modelActiveLarge;
    smallRegs_t modelActiveSmall;
    logic [`CP_LARGE_COUNT-1:0] pendUpper;
    logic [`CP_LARGE_COUNT-1:0] pendLower;
    logic [`CP_LARGE_COUNT-1:0] wrUpper;
    logic [`CP_LARGE_COUNT-1:0] wrLower;
    logic [`CP_SMALL_COUNT-1:0] wrSmall;
    // updates waiting for the next apply
    logic [`CP_LARGE_COUNT-1:0] latchLarge;
    logic [`CP_SMALL_COUNT-1:0] latchSmall;

    logic [7:0] respQueue[$];
    logic [PULSE_W-1:0] pulseQueue[$];

    int testChecks;
    int testErrors;
    int totalChecks;
    int testsRun;

    function automatic string testName(input int id);
        case (id)
            0: return "writeRead";
            1: return "invalidCode";
            2: return "pairUpdate";
            3: return "applyStrobe";
            4: return "wipeMix";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkValue(input string item, input logic [63:0] expected,
                              input logic [63:0] actual);
        testChecks++;
        totalChecks++;
        if (expected !== actual) begin
            testErrors++;
            errorTotal++;
            $display("Fail %s expected %0h actual %0h (%s)", testName(testId), expected,
                     actual, item);
        end
    endtask

    task automatic reportProblem(input string what);
        testErrors++;
        errorTotal++;
        $display("Error in %s: %s", testName(testId), what);
    endtask

    // addressed half-word for a valid code
    function automatic logic [`CP_HALF_WIDTH-1:0] halfAt(input int code);
        int idx;
        if (code < `CP_SMALL_CODE_BASE) begin
            idx = (code - `CP_LARGE_CODE_BASE) / 2;
            if ((code - `CP_LARGE_CODE_BASE) % 2 == 0) begin
                return shadowLarge[idx][31:16];
            end
            return shadowLarge[idx][15:0];
        end
        return shadowSmall[code - `CP_SMALL_CODE_BASE];
    endfunction

    task automatic runCommand(input cmdWord_t word);
        int code;
        int idx;
        logic [`CP_HALF_WIDTH-1:0] value;
        logic [PULSE_W-1:0] pulse;
        code = int'(word.code);
        pulse = '0;
        if (word.isRead) begin
            if (code >= `CP_LARGE_CODE_BASE && code < `CP_SMALL_CODE_BASE + `CP_SMALL_COUNT) begin
                value = halfAt(code);
                respQueue.push_back(`CP_RESP_READ);
                respQueue.push_back(value[15:8]);
                respQueue.push_back(value[7:0]);
            end else begin
                respQueue.push_back(`CP_RESP_ERR);
            end
        end else if (code >= `CP_LARGE_CODE_BASE && code < `CP_SMALL_CODE_BASE) begin
            idx = (code - `CP_LARGE_CODE_BASE) / 2;
            if ((code - `CP_LARGE_CODE_BASE) % 2 == 0) begin
                shadowLarge[idx][31:16] = word.data;
                wrUpper[idx] = 1'b1;
                pendUpper[idx] = 1'b1;
            end else begin
                shadowLarge[idx][15:0] = word.data;
                wrLower[idx] = 1'b1;
                pendLower[idx] = 1'b1;
            end
            // pair complete, one pulse and the pending halves start over
            if (pendUpper[idx] && pendLower[idx]) begin
                pendUpper[idx] = 1'b0;
                pendLower[idx] = 1'b0;
                latchLarge[idx] = 1'b1;
                pulse[`CP_SMALL_COUNT + idx] = 1'b1;
                pulseQueue.push_back(pulse);
            end
            respQueue.push_back(`CP_RESP_ACK);
        end else if (code >= `CP_SMALL_CODE_BASE &&
                     code < `CP_SMALL_CODE_BASE + `CP_SMALL_COUNT) begin
            idx = code - `CP_SMALL_CODE_BASE;
            shadowSmall[idx] = word.data;
            wrSmall[idx] = 1'b1;
            latchSmall[idx] = 1'b1;
            pulse[idx] = 1'b1;
            pulseQueue.push_back(pulse);
            respQueue.push_back(`CP_RESP_ACK);
        end else begin
            respQueue.push_back(`CP_RESP_NAK);
        end
    endtask

    // ------------------------------------------------------------------------
    // compare outputs, then advance the model on the same edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            byteCount = 2'd0;
            shadowLarge = '0;
            shadowSmall = '0;
            modelActiveLarge = '0;
            modelActiveSmall = '0;
            pendUpper = '0;
            pendLower = '0;
            wrUpper = '0;
            wrLower = '0;
            wrSmall = '0;
            latchLarge = '0;
            latchSmall = '0;
            respQueue.delete();
            pulseQueue.delete();
            testChecks = 0;
            testErrors = 0;
            totalChecks = 0;
            testsRun = 0;
            errorTotal = 0;
        end else begin
            if (respValid) begin
                if (respQueue.size() == 0) begin
                    reportProblem("response byte arrived with none expected");
                end else begin
                    checkValue("response byte", respQueue.pop_front(), respByte);
                end
            end
            if (|{largeUpdate, smallUpdate}) begin
                if (pulseQueue.size() == 0) begin
                    reportProblem("update pulse fired with none expected");
                end else begin
                    checkValue("update pulses", pulseQueue.pop_front(),
                               {largeUpdate, smallUpdate});
                end
            end
            if (checkPoint) begin
                checkValue("allWritten", &{wrUpper, wrLower, wrSmall}, allWritten);
                for (int i = 0; i < `CP_LARGE_COUNT; i++) begin
                    checkValue("activeLarge", modelActiveLarge[i], activeLarge[i]);
                end
                for (int j = 0; j < `CP_SMALL_COUNT; j++) begin
                    checkValue("activeSmall", modelActiveSmall[j], activeSmall[j]);
                end
            end
            if (wipe) begin
                // latch pending bits survive a wipe
                byteCount = 2'd0;
                shadowLarge = '0;
                shadowSmall = '0;
                pendUpper = '0;
                pendLower = '0;
                wrUpper = '0;
                wrLower = '0;
                wrSmall = '0;
            end else if (byteValid) begin
                if (byteCount == 2'd3) begin
                    runCommand({gathered, byteIn});
                end else begin
                    gathered = {gathered[15:0], byteIn};
                end
                byteCount = byteCount + 2'd1;
            end
            if (applyStrobe) begin
                for (int i = 0; i < `CP_LARGE_COUNT; i++) begin
                    if (latchLarge[i]) begin
                        modelActiveLarge[i] = shadowLarge[i];
                    end
                end
                for (int j = 0; j < `CP_SMALL_COUNT; j++) begin
                    if (latchSmall[j]) begin
                        modelActiveSmall[j] = shadowSmall[j];
                    end
                end
                latchLarge = '0;
                latchSmall = '0;
            end
            if (testDone) begin
                $display("test %0d %s: %0d checks, %0d errors", testId, testName(testId),
                         testChecks, testErrors);
                testsRun++;
                testChecks = 0;
                testErrors = 0;
            end
            if (finalize) begin
                $display("summary: %0d tests, %0d checks, %0d errors", testsRun,
                         totalChecks, errorTotal);
            end
        end
        drained = (respQueue.size() == 0) && (pulseQueue.size() == 0);
    end

endmodule

// File: tb/ctrlParamLinkTb.sv
`timescale 1ns/1ps

`include "ctrlParam_settings.svh"

module ctrlParamLinkTb;

    import ctrlParamPkg::*;

    localparam int WR_PAIRS     = 16;
    localparam int INVALID_CMDS = 12;
    localparam int PAIR_ROUNDS  = 8;
    localparam int APPLY_CMDS   = 24;
    localparam int MIX_CMDS     = 64;
    // mix commands counted twice to cover partial words
    localparam int BYTE_BUDGET  =
        (WR_PAIRS * 2 + INVALID_CMDS + PAIR_ROUNDS * 3 + APPLY_CMDS + MIX_CMDS * 2) * 4;

    logic clk;
    logic rst;
    logic [7:0] byteIn;
    logic byteValid;
    logic wipe;
    logic applyStrobe;
    logic [7:0] respByte;
    logic respValid;
    largeRegs_t activeLarge;
    smallRegs_t activeSmall;
    logic [`CP_LARGE_COUNT-1:0] largeUpdate;
    logic [`CP_SMALL_COUNT-1:0] smallUpdate;
    logic allWritten;

    int testId;
    logic checkPoint;
    logic testDone;
    logic finalize;
    logic drained;
    int errorTotal;
    logic [15:0] lfsrState;

    ctrlParamLink dut (
        .clk         (clk),
        .rst         (rst),
        .byteIn      (byteIn),
        .byteValid   (byteValid),
        .wipe        (wipe),
        .applyStrobe (applyStrobe),
        .respByte    (respByte),
        .respValid   (respValid),
        .activeLarge (activeLarge),
        .activeSmall (activeSmall),
        .largeUpdate (largeUpdate),
        .smallUpdate (smallUpdate),
        .allWritten  (allWritten)
    );

    ctrlParamChecker chk (
        .clk         (clk),
        .rst         (rst),
        .byteIn      (byteIn),
        .byteValid   (byteValid),
        .wipe        (wipe),
        .applyStrobe (applyStrobe),
        .respByte    (respByte),
        .respValid   (respValid),
        .activeLarge (activeLarge),
        .activeSmall (activeSmall),
        .largeUpdate (largeUpdate),
        .smallUpdate (smallUpdate),
        .allWritten  (allWritten),
        .testId      (testId),
        .checkPoint  (checkPoint),
        .testDone    (testDone),
        .finalize    (finalize),
        .drained     (drained),
        .errorTotal  (errorTotal)
    );

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic int takeBits(input int count);
        int value;
        value = 0;
        for (int k = 0; k < count; k++) begin
            lfsrState = {lfsrState[14:0],
                         lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
            value = (value << 1) | int'(lfsrState[0]);
        end
        return value;
    endfunction

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic sendByte(input logic [7:0] value);
        byteIn = value;
        byteValid = 1'b1;
        idleCycles(1);
        byteValid = 1'b0;
    endtask

    task automatic sendCommand(input logic isRead, input int code, input int data,
                               input bit gaps);
        cmdWord_t word;
        word.isRead = isRead;
        word.code = code[`CP_CODE_WIDTH-1:0];
        word.reserved = 8'(takeBits(8));
        word.data = data[15:0];
        // most significant byte first
        for (int k = 3; k >= 0; k--) begin
            if (gaps) begin
                idleCycles(takeBits(2));
            end
            sendByte(word[8*k +: 8]);
        end
    endtask

    task automatic waitDrained();
        do begin
            idleCycles(1);
        end while (!drained);
    endtask

    task automatic takeCheckpoint();
        checkPoint = 1'b1;
        idleCycles(1);
        checkPoint = 1'b0;
    endtask

    task automatic pulseApply();
        applyStrobe = 1'b1;
        idleCycles(1);
        applyStrobe = 1'b0;
    endtask

    task automatic pulseWipe();
        wipe = 1'b1;
        idleCycles(1);
        wipe = 1'b0;
    endtask

    task automatic closeTest();
        waitDrained();
        takeCheckpoint();
        testDone = 1'b1;
        idleCycles(1);
        testDone = 1'b0;
        testId++;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (BYTE_BUDGET * 8 + 1000) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        int code;
        int pick;
        int first;
        lfsrState = 16'd27725;
        rst = 1'b1;
        byteIn = 8'h00;
        byteValid = 1'b0;
        wipe = 1'b0;
        applyStrobe = 1'b0;
        testId = 0;
        checkPoint = 1'b0;
        testDone = 1'b0;
        finalize = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // every valid code written then read back with allWritten checked per pair
        for (int n = 0; n < WR_PAIRS; n++) begin
            code = `CP_LARGE_CODE_BASE + n % 8;
            sendCommand(1'b0, code, takeBits(16), 1'b0);
            sendCommand(1'b1, code, takeBits(16), 1'b0);
            waitDrained();
            takeCheckpoint();
        end
        closeTest();

        // code 0 and codes 9 to 15
        for (int n = 0; n < INVALID_CMDS; n++) begin
            pick = takeBits(3);
            code = (pick == 0) ? 0 : 8 + pick;
            sendCommand(1'(takeBits(1)), code, takeBits(16), 1'b0);
            sendCommand(1'b1, `CP_LARGE_CODE_BASE + takeBits(3), 0, 1'b0);
        end
        closeTest();

        // halves in either order with a small write between them
        for (int n = 0; n < PAIR_ROUNDS; n++) begin
            code = `CP_LARGE_CODE_BASE + 2 * takeBits(1);
            first = takeBits(1);
            sendCommand(1'b0, code + first, takeBits(16), 1'b1);
            sendCommand(1'b0, `CP_SMALL_CODE_BASE + takeBits(2), takeBits(16), 1'b1);
            sendCommand(1'b0, code + 1 - first, takeBits(16), 1'b1);
        end
        closeTest();

        for (int n = 0; n < APPLY_CMDS; n++) begin
            sendCommand(1'b0, `CP_LARGE_CODE_BASE + takeBits(3), takeBits(16), 1'b1);
            if (takeBits(2) == 0) begin
                waitDrained();
                pulseApply();
                takeCheckpoint();
            end
        end
        waitDrained();
        pulseApply();
        closeTest();

        // random codes mixed with wipes over partial words and applies
        for (int n = 0; n < MIX_CMDS; n++) begin
            sendCommand(1'(takeBits(1)), takeBits(4), takeBits(16), 1'b1);
            pick = takeBits(4);
            if (pick == 0) begin
                waitDrained();
                repeat (takeBits(2)) sendByte(8'(takeBits(8)));
                pulseWipe();
                takeCheckpoint();
            end else if (pick < 3) begin
                waitDrained();
                pulseApply();
                takeCheckpoint();
            end else if (pick < 5) begin
                waitDrained();
                takeCheckpoint();
            end
        end
        closeTest();

        finalize = 1'b1;
        idleCycles(1);
        finalize = 1'b0;
        if (errorTotal == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: ctrlParamLink.f
+incdir+include
rtl/ctrlParamPkg.sv
rtl/cmdFrameAssembler.sv
rtl/ctrlParamDecoder.sv
rtl/paramShadowLatch.sv
rtl/responseEncoder.sv
rtl/ctrlParamLink.sv
tb/ctrlParamChecker.sv
tb/ctrlParamLinkTb.sv
